/* compile.f */
+incdir+logic
logic/alu_pkg.sv
logic/alu_result_if.sv
logic/alu_arith_unit.sv
logic/alu_logic_unit.sv
logic/alu_flag_merge.sv
logic/alu_exec_top.sv
test/tb_alu_exec.sv

/* Makefile */
TOP = tb_alu_exec

.PHONY: all lint clean

all:
	verilator --binary --timing -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* test/tb_alu_exec.sv */
// ~~~~~~~~~~~~~~~~~~~~
// execute stage testbench
// seeded random operations checked against a flag-level reference model
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "alu_defs.svh"

module tb_alu_exec;
    import alu_pkg::*;

    localparam flags_t LIVE = 8'hD7;    // S Z H V N C
    localparam int N_OPS = 300 + 80 + 150 + 60 + 12 + 200 + 200 + 150;
    localparam int CYCLE_LIMIT = 2 * N_OPS + 100;

    typedef struct packed {
        alu_op_t o;
        word_t   d;
        flags_t  f;
        logic    j;
        size_t   s;
    } expect_t;

    logic    clk = 1'b0;
    logic    rst, issue, sel_imm, djnz, done, issue_d, m_djnz;
    alu_op_t op;
    size_t   size, size_q;
    word_t   op0, op1, imm, dout, m_dout, cnt;
    flags_t  flags, m_flags;
    expect_t exp_q[$];
    int      errors = 0, checks = 0, cycles = 0, err_mark = 0;
    alu_op_t arith_ops[6] = '{OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_CP, OP_NEG};
    alu_op_t bool_ops[5]  = '{OP_AND, OP_OR, OP_XOR, OP_CPL, OP_MOVE};

    alu_exec_top DUT (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_word(input string what, input word_t got, input word_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_flags(input string what, input flags_t got, input flags_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic check_size(input string what, input size_t got, input size_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t: %s is %s, expected %s", $time, what, got.name(),
                     want.name());
        end
    endtask

    // done must follow each captured issue by one cycle
    always @(negedge clk) begin
        expect_t e;
        if (!rst) begin
            if (done !== issue_d) begin
                errors++;
                $display("error at %0t: done is %b but issue one cycle earlier was %b",
                         $time, done, issue_d);
            end
            if (issue_d && exp_q.size() > 0) begin
                e = exp_q.pop_front();
                if (done === 1'b1) begin
                    check_word({"dout after ", e.o.name()}, dout, e.d);
                    check_flags({"flags after ", e.o.name()}, flags, e.f);
                    check_bit({"djnz after ", e.o.name()}, djnz, e.j);
                    check_size({"size_q after ", e.o.name()}, size_q, e.s);
                end
            end
        end
        issue_d = issue;
    end

    function automatic int bits_of(input size_t sz);
        return (sz == SZ_BYTE) ? 8 : (sz == SZ_WORD) ? 16 : 32;
    endfunction

    // a + b + cin or a - b - cin, flags taken at the operand size
    task automatic addsub(input size_t sz, input word_t a, input word_t b, input logic cin,
                          input logic sub, output word_t r, output flags_t f);
        longint unsigned mask, am, bm, ci;
        int   w;
        logic sa, sb;
        w    = bits_of(sz);
        mask = (64'd1 << w) - 64'd1;
        am   = {32'd0, a} & mask;
        bm   = {32'd0, b} & mask;
        ci   = {63'd0, cin};
        r    = sub ? a - b - word_t'(cin) : a + b + word_t'(cin);
        sa   = a[w-1];
        sb   = b[w-1];
        f    = '0;
        f[`FLAG_S] = r[w-1];
        f[`FLAG_Z] = (r << (32 - w)) == '0;
        f[`FLAG_N] = sub;
        if (sub) begin
            f[`FLAG_C] = am < bm + ci;     // borrow
            f[`FLAG_H] = {1'b0, a[3:0]} < {1'b0, b[3:0]} + {4'd0, cin};
            f[`FLAG_V] = (sa != sb) && (r[w-1] != sa);
        end else begin
            f[`FLAG_C] = am + bm + ci > mask;
            f[`FLAG_H] = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin} > 5'd15;
            f[`FLAG_V] = (sa == sb) && (r[w-1] != sa);
        end
    endtask

    task automatic apply_model(input alu_op_t o, input size_t sz, input word_t a,
                               input word_t b, input word_t im, input logic si);
        word_t  src, r;
        flags_t f, m;
        logic   wr, cin;
        int     w;
        src = si ? im : b;
        cin = m_flags[`FLAG_C];
        w   = bits_of(sz);
        r   = '0;
        f   = '0;
        m   = '0;
        wr  = 1'b1;
        case (o)
            OP_ADD, OP_ADC, OP_INC: begin
                addsub(sz, a, src, (o == OP_ADC) & cin, 1'b0, r, f);
                m = LIVE;
            end
            OP_SUB, OP_SBC, OP_CP, OP_DEC: begin
                addsub(sz, a, src, (o == OP_SBC) & cin, 1'b1, r, f);
                m  = LIVE;
                wr = (o != OP_CP);
            end
            OP_NEG: begin
                addsub(sz, '0, a, 1'b0, 1'b1, r, f);
                m = LIVE;
            end
            OP_DJNZ: begin
                r = a;
                if (sz == SZ_WORD) begin
                    r[15:0] = a[15:0] - 16'd1;
                    m_djnz  = (r[15:0] == 16'd0);
                end else begin
                    r[7:0] = a[7:0] - 8'd1;     // long size counts a byte too
                    m_djnz = (r[7:0] == 8'd0);
                end
            end
            OP_AND, OP_OR, OP_XOR: begin
                r = (o == OP_AND) ? (a & src) : (o == OP_OR) ? (a | src) : (a ^ src);
                f[`FLAG_S] = r[w-1];
                f[`FLAG_Z] = (r << (32 - w)) == '0;
                f[`FLAG_H] = (o == OP_AND);
                f[`FLAG_V] = ($countones(r & ((sz == SZ_BYTE) ? 32'hff : 32'hffff)) % 2) == 0;
                m = LIVE;
            end
            OP_CPL: begin
                r = ~src;
                f[`FLAG_H] = 1'b1;
                f[`FLAG_N] = 1'b1;
                m = f;
            end
            OP_MOVE: r = src;
            OP_BIT: begin
                f[`FLAG_Z] = ~b[im[3:0]];
                f[`FLAG_H] = 1'b1;
                m = f;
                m[`FLAG_Z] = 1'b1;
                m[`FLAG_N] = 1'b1;
                wr = 1'b0;
            end
            OP_BS1F, OP_BS1B: begin
                for (int i = 0; i < 16; i++) begin
                    if (o == OP_BS1F ? b[i] : b[15-i]) begin
                        r = (o == OP_BS1F) ? i : 15 - i;
                        break;
                    end
                end
                f[`FLAG_V] = (b[15:0] == 16'd0);
                m[`FLAG_V] = 1'b1;
            end
            OP_MIRR: begin
                for (int i = 0; i < 16; i++) begin
                    r = {r[30:0], a[i]};    // bit 0 ends up on top
                end
            end
            OP_EXTS: begin
                if (sz == SZ_WORD)
                    r = (a & 32'h0000_00ff) | (a[7] ? 32'h0000_ff00 : 32'h0);
                else
                    r = (a & 32'h0000_ffff) | (a[15] ? 32'hffff_0000 : 32'h0);
            end
            OP_EXTZ: r = a & ((sz == SZ_WORD) ? 32'h0000_00ff : 32'h0000_ffff);
            OP_CCF: begin
                f[`FLAG_C] = ~cin;
                m[`FLAG_C] = 1'b1;
                m[`FLAG_N] = 1'b1;
                wr = 1'b0;
            end
            default: wr = 1'b0;     // unclaimed opcode
        endcase
        if (o == OP_INC || o == OP_DEC) begin
            m[`FLAG_C] = 1'b0;
            if (sz != SZ_BYTE)
                m = '0;
        end
        if (wr)
            m_dout = r;
        m_flags = (m_flags & ~m) | (f & m);
        exp_q.push_back(expect_t'{o, m_dout, m_flags, m_djnz, sz});
    endtask

    task automatic send(input alu_op_t o, input size_t sz, input word_t a, input word_t b,
                        input word_t im, input logic si);
        @(posedge clk);
        issue   <= 1'b1;
        op      <= o;
        size    <= sz;
        op0     <= a;
        op1     <= b;
        imm     <= im;
        sel_imm <= si;
        apply_model(o, sz, a, b, im, si);
    endtask

    task automatic send_rand(input alu_op_t o);
        word_t a, b, im;
        a  = $urandom;
        b  = $urandom;
        im = $urandom;
        case ($urandom_range(0, 7))
            0: b = a;               // zero results
            1: b[15:0] = 16'd0;     // empty bit search
            2: im = a;
            default: ;
        endcase
        send(o, size_t'($urandom_range(0, 2)), a, b, im, 1'($urandom_range(0, 1)));
    endtask

    task automatic rest();
        @(posedge clk);
        issue <= 1'b0;
    endtask

    task automatic finish_test(input string name);
        rest();
        while (exp_q.size() > 0)
            @(posedge clk);
        $display("%-26s %s, %0d errors", name, (errors == err_mark) ? "ok" : "wrong",
                 errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        void'($urandom(32'h3231));
        rst     = 1'b1;
        issue   = 1'b0;
        op      = OP_MOVE;
        size    = SZ_BYTE;
        op0     = '0;
        op1     = '0;
        imm     = '0;
        sel_imm = 1'b0;
        issue_d = 1'b0;
        m_dout  = '0;
        m_flags = '0;
        m_djnz  = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_word("dout after reset", dout, '0);
        check_flags("flags after reset", flags, '0);
        check_bit("djnz after reset", djnz, 1'b0);
        check_bit("done after reset", done, 1'b0);
        check_size("size_q after reset", size_q, SZ_BYTE);
        finish_test("reset state");

        repeat (300) send_rand(arith_ops[$urandom_range(0, 5)]);
        repeat (80) send_rand($urandom_range(0, 1) ? OP_ADC : OP_SBC);  // carry chains
        finish_test("add sub compare negate");

        repeat (150) send_rand($urandom_range(0, 1) ? OP_INC : OP_DEC);
        repeat (60) begin
            cnt = $urandom;
            cnt[15:0] = 16'($urandom_range(0, 3));
            send(OP_DJNZ, size_t'($urandom_range(0, 2)), cnt, $urandom, $urandom, 1'b0);
        end
        for (int run = 0; run < 4; run++) begin
            cnt = 32'h5a5a_0003;
            repeat (3) begin
                send(OP_DJNZ, run[0] ? SZ_WORD : SZ_BYTE, cnt, '0, '0, 1'b0);
                cnt = m_dout;   // next pass counts from the new value
            end
        end
        finish_test("inc dec djnz");

        repeat (200) send_rand(bool_ops[$urandom_range(0, 4)]);
        finish_test("logic cpl move");

        repeat (200) send_rand(alu_op_t'($urandom_range(14, 20)));
        finish_test("bit search mirror extend");

        repeat (150) begin
            send_rand(alu_op_t'($urandom_range(0, 21)));
            if ($urandom_range(0, 1) == 1)
                rest();
        end
        finish_test("done timing with gaps");

        $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

/* logic/alu_exec_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// execute stage top
// arithmetic and logic units side by side, one merge register stage
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module alu_exec_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue,
    input  alu_pkg::alu_op_t op,
    input  alu_pkg::size_t   size,
    input  alu_pkg::word_t   op0,      // destination
    input  alu_pkg::word_t   op1,      // source
    input  alu_pkg::word_t   imm,
    input  logic             sel_imm,
    output alu_pkg::word_t   dout,
    output alu_pkg::flags_t  flags,
    output logic             djnz,
    output logic             done,
    output alu_pkg::size_t   size_q
);

    logic carry;    // registered C flag

    alu_result_if ar_if ();
    alu_result_if lg_if ();

    alu_arith_unit u_arith (
        .size     (size),
        .op       (op),
        .op0      (op0),
        .op1      (op1),
        .imm      (imm),
        .sel_imm  (sel_imm),
        .carry_in (carry),
        .res      (ar_if.unit)
    );

    alu_logic_unit u_logic (
        .size     (size),
        .op       (op),
        .op0      (op0),
        .op1      (op1),
        .imm      (imm),
        .sel_imm  (sel_imm),
        .carry_in (carry),
        .res      (lg_if.unit)
    );

    alu_flag_merge u_merge (
        .clk    (clk),
        .rst    (rst),
        .issue  (issue),
        .size   (size),
        .ar     (ar_if.merge),
        .lg     (lg_if.merge),
        .dout   (dout),
        .flags  (flags),
        .carry  (carry),
        .djnz   (djnz),
        .done   (done),
        .size_q (size_q)
    );

endmodule

/* logic/alu_flag_merge.sv */
// ~~~~~~~~~~~~~~~~~~~~
// result and flag merge
// picks the claiming unit, registers result, flags and loop flag,
// pulses done one cycle after issue
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_flag_merge (
    input  logic            clk,
    input  logic            rst,
    input  logic            issue,
    input  alu_pkg::size_t  size,
    alu_result_if.merge     ar,
    alu_result_if.merge     lg,
    output alu_pkg::word_t  dout,
    output alu_pkg::flags_t flags,
    output logic            carry,
    output logic            djnz,
    output logic            done,
    output alu_pkg::size_t  size_q
);
    import alu_pkg::*;

    // bits 5 and 3 never get written
    localparam flags_t FLAG_LIVE = 8'((1 << `FLAG_S) | (1 << `FLAG_Z) | (1 << `FLAG_H) |
                                      (1 << `FLAG_V) | (1 << `FLAG_N) | (1 << `FLAG_C));

    word_t  sel_result;
    logic   sel_wr, sel_djnz, sel_djnz_we;
    flags_t sel_flags, sel_mask;

    always_comb begin
        sel_result  = '0;
        sel_wr      = 1'b0;
        sel_flags   = '0;
        sel_mask    = '0;
        sel_djnz    = 1'b0;
        sel_djnz_we = 1'b0;
        if (ar.hit) begin
            sel_result  = ar.result;
            sel_wr      = ar.wr_result;
            sel_flags   = ar.nx_flags;
            sel_mask    = ar.flag_mask & FLAG_LIVE;
            sel_djnz    = ar.nx_djnz;
            sel_djnz_we = ar.djnz_we;
        end else if (lg.hit) begin
            sel_result  = lg.result;
            sel_wr      = lg.wr_result;
            sel_flags   = lg.nx_flags;
            sel_mask    = lg.flag_mask & FLAG_LIVE;
            sel_djnz    = lg.nx_djnz;
            sel_djnz_we = lg.djnz_we;
        end
        // unclaimed opcode leaves everything as is
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout   <= '0;
            flags  <= '0;
            djnz   <= 1'b0;
            done   <= 1'b0;
            size_q <= SZ_BYTE;
        end else begin
            done <= issue;  // one cycle after issue
            if (issue) begin
                size_q <= size;
                if (sel_wr) begin
                    dout <= sel_result;
                end
                flags <= (flags & ~sel_mask) | (sel_flags & sel_mask);
                if (sel_djnz_we) begin
                    djnz <= sel_djnz;
                end
            end
        end
    end

    // registered carry back to both units for ADC, SBC and CCF
    assign carry = flags[`FLAG_C];

endmodule

/* logic/alu_logic_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~
// logic unit
// bitwise ops, move, bit test and search, mirror, extend, CCF
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_logic_unit (
    input  alu_pkg::size_t   size,
    input  alu_pkg::alu_op_t op,
    input  alu_pkg::word_t   op0,
    input  alu_pkg::word_t   op1,
    input  alu_pkg::word_t   imm,
    input  logic             sel_imm,
    input  logic             carry_in,
    alu_result_if.unit       res
);
    import alu_pkg::*;

    localparam flags_t M_BOOL = 8'((1 << `FLAG_S) | (1 << `FLAG_Z) | (1 << `FLAG_H) |
                                   (1 << `FLAG_V) | (1 << `FLAG_N) | (1 << `FLAG_C));

    word_t   src, r;
    bitpos_t bit_idx;
    logic    hit, wr, hw_zero, parity_even;
    flags_t  nf, mask;

    // index of lowest set bit, 0 when none
    function automatic logic [3:0] find_low(input logic [15:0] v);
        logic [3:0] idx;
        idx = '0;
        for (int i = 15; i >= 0; i--) begin
            if (v[i]) idx = 4'(i);
        end
        return idx;
    endfunction

    // index of highest set bit, 0 when none
    function automatic logic [3:0] find_high(input logic [15:0] v);
        logic [3:0] idx;
        idx = '0;
        for (int i = 0; i < 16; i++) begin
            if (v[i]) idx = 4'(i);
        end
        return idx;
    endfunction

    function automatic logic [15:0] mirror16(input logic [15:0] v);
        logic [15:0] m;
        for (int i = 0; i < 16; i++) begin
            m[i] = v[15-i];
        end
        return m;
    endfunction

    assign src     = sel_imm ? imm : op1;
    assign bit_idx = imm[3:0];
    assign hw_zero = op1[15:0] == 16'd0;

    always_comb begin
        hit = 1'b1;
        wr  = 1'b1;
        r   = src;
        case (op)
            OP_MOVE: r = src;
            OP_AND:  r = op0 & src;
            OP_OR:   r = op0 | src;
            OP_XOR:  r = op0 ^ src;
            OP_CPL:  r = ~src;
            OP_BS1F: r = word_t'(find_low(op1[15:0]));
            OP_BS1B: r = word_t'(find_high(op1[15:0]));
            OP_MIRR: r = {16'd0, mirror16(op0[15:0])};
            OP_EXTS: r = (size == SZ_WORD) ? {16'd0, {8{op0[7]}}, op0[7:0]}
                                           : {{16{op0[15]}}, op0[15:0]};
            OP_EXTZ: r = (size == SZ_WORD) ? {24'd0, op0[7:0]} : {16'd0, op0[15:0]};
            OP_BIT, OP_CCF: wr = 1'b0;      // flags only
            default: begin
                hit = 1'b0;
                wr  = 1'b0;
            end
        endcase
    end

    // even parity over low byte or low half-word
    assign parity_even = (size == SZ_BYTE) ? ~^r[7:0] : ~^r[15:0];

    always_comb begin
        nf   = '0;
        mask = '0;
        case (op)
            OP_AND, OP_OR, OP_XOR: begin
                nf[`FLAG_S] = sign_at(size, r);
                nf[`FLAG_Z] = zero_at(size, r);
                nf[`FLAG_H] = (op == OP_AND);
                nf[`FLAG_V] = parity_even;
                mask        = M_BOOL;   // N and C cleared
            end
            OP_CPL: begin
                nf[`FLAG_H] = 1'b1;
                nf[`FLAG_N] = 1'b1;
                mask        = 8'((1 << `FLAG_H) | (1 << `FLAG_N));
            end
            OP_BIT: begin
                nf[`FLAG_Z] = ~op1[bit_idx];
                nf[`FLAG_H] = 1'b1;
                mask        = 8'((1 << `FLAG_Z) | (1 << `FLAG_H) | (1 << `FLAG_N));
            end
            OP_BS1F, OP_BS1B: begin
                nf[`FLAG_V] = hw_zero;  // nothing found
                mask        = 8'(1 << `FLAG_V);
            end
            OP_CCF: begin
                nf[`FLAG_C] = ~carry_in;
                mask        = 8'((1 << `FLAG_C) | (1 << `FLAG_N));
            end
            default: ;
        endcase
    end

    assign res.hit       = hit;
    assign res.result    = r;
    assign res.wr_result = wr;
    assign res.nx_flags  = nf;
    assign res.flag_mask = mask;
    assign res.nx_djnz   = 1'b0;
    assign res.djnz_we   = 1'b0;

endmodule

/* logic/alu_arith_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~
// arithmetic unit
// add/subtract with nibble, byte and word carries, compare,
// inc/dec, negate and the DJNZ count-down
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_arith_unit (
    input  alu_pkg::size_t   size,
    input  alu_pkg::alu_op_t op,
    input  alu_pkg::word_t   op0,
    input  alu_pkg::word_t   op1,
    input  alu_pkg::word_t   imm,
    input  logic             sel_imm,
    input  logic             carry_in,
    alu_result_if.unit       res
);
    import alu_pkg::*;

    localparam flags_t M_ALL = 8'((1 << `FLAG_S) | (1 << `FLAG_Z) | (1 << `FLAG_H) |
                                  (1 << `FLAG_V) | (1 << `FLAG_N) | (1 << `FLAG_C));
    localparam flags_t M_INC = M_ALL & ~8'(1 << `FLAG_C);  // inc/dec keep C

    word_t  src, a, b, b_eff, sum, dj_res;
    logic   hit, wr, sub, cuse, neg, djnz_op;
    logic   c0, c4, c8, c16, c32, c_top;
    logic   a_s, b_s, r_s, dj_zero;
    flags_t nf, mask;

    assign src = sel_imm ? imm : op1;

    always_comb begin
        hit     = 1'b1;
        wr      = 1'b1;
        sub     = 1'b0;
        cuse    = 1'b0;
        neg     = 1'b0;
        djnz_op = 1'b0;
        mask    = M_ALL;
        case (op)
            OP_ADD: ;
            OP_ADC: cuse = 1'b1;
            OP_INC: mask = (size == SZ_BYTE) ? M_INC : '0;
            OP_SUB: sub = 1'b1;
            OP_SBC: begin
                sub  = 1'b1;
                cuse = 1'b1;
            end
            OP_CP: begin
                sub = 1'b1;
                wr  = 1'b0;     // flags only
            end
            OP_DEC: begin
                sub  = 1'b1;
                mask = (size == SZ_BYTE) ? M_INC : '0;
            end
            OP_NEG: begin
                sub = 1'b1;
                neg = 1'b1;
            end
            OP_DJNZ: begin
                sub     = 1'b1;
                djnz_op = 1'b1;
                mask    = '0;
            end
            default: begin
                hit  = 1'b0;
                wr   = 1'b0;
                mask = '0;
            end
        endcase
    end

    // subtraction runs as a + ~b + 1, borrow is the inverted carry
    assign a     = neg ? '0 : op0;
    assign b     = djnz_op ? word_t'(1) : (neg ? op0 : src);
    assign b_eff = sub ? ~b : b;
    assign c0    = sub ^ (cuse & carry_in);

    always_comb begin
        {c4,  sum[3:0]}   = {1'b0, a[3:0]}   + {1'b0, b_eff[3:0]}   + {4'd0, c0};
        {c8,  sum[7:4]}   = {1'b0, a[7:4]}   + {1'b0, b_eff[7:4]}   + {4'd0, c4};
        {c16, sum[15:8]}  = {1'b0, a[15:8]}  + {1'b0, b_eff[15:8]}  + {8'd0, c8};
        {c32, sum[31:16]} = {1'b0, a[31:16]} + {1'b0, b_eff[31:16]} + {16'd0, c16};
    end

    always_comb begin
        case (size)
            SZ_BYTE: c_top = c8;
            SZ_WORD: c_top = c16;
            default: c_top = c32;
        endcase
    end

    assign a_s = sign_at(size, a);
    assign b_s = sign_at(size, b_eff);
    assign r_s = sign_at(size, sum);

    always_comb begin
        nf          = '0;
        nf[`FLAG_S] = r_s;
        nf[`FLAG_Z] = zero_at(size, sum);
        nf[`FLAG_H] = c4 ^ sub;
        nf[`FLAG_V] = (a_s == b_s) && (r_s != a_s);   // signed overflow
        nf[`FLAG_N] = sub;
        nf[`FLAG_C] = c_top ^ sub;
    end

    // count-down is 16 bits at word size, 8 bits otherwise
    assign dj_res  = (size == SZ_WORD) ? {op0[31:16], sum[15:0]} : {op0[31:8], sum[7:0]};
    assign dj_zero = (size == SZ_WORD) ? (sum[15:0] == 16'd0) : (sum[7:0] == 8'd0);

    assign res.hit       = hit;
    assign res.result    = djnz_op ? dj_res : sum;
    assign res.wr_result = wr;
    assign res.nx_flags  = nf;
    assign res.flag_mask = mask;
    assign res.nx_djnz   = dj_zero;
    assign res.djnz_we   = djnz_op;

endmodule

/* logic/alu_result_if.sv */
// ~~~~~~~~~~~~~~~~~~~~
// unit result bundle
// one unit's proposed result and flag update for the merge block
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface alu_result_if;
    import alu_pkg::*;

    logic   hit;        // opcode claimed by this unit
    word_t  result;
    logic   wr_result;
    flags_t nx_flags;
    flags_t flag_mask;  // set bits update
    logic   nx_djnz;
    logic   djnz_we;

    modport unit (
        output hit, result, wr_result, nx_flags, flag_mask, nx_djnz, djnz_we
    );

    modport merge (
        input hit, result, wr_result, nx_flags, flag_mask, nx_djnz, djnz_we
    );

endinterface

/* logic/alu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// execute stage types
// operand, size, opcode and flag types plus size helpers
// ~~~~~~~~~~~~~~~~~~~~

`include "alu_defs.svh"

package alu_pkg;

    typedef logic [`ALU_DW-1:0] word_t;
    typedef logic [7:0]         flags_t;
    typedef logic [3:0]         bitpos_t;   // bit index for BIT

    typedef enum logic [1:0] {
        SZ_BYTE,
        SZ_WORD,
        SZ_LONG
    } size_t;

    typedef enum logic [`ALU_OPW-1:0] {
        OP_MOVE, OP_ADD,  OP_ADC,  OP_INC,
        OP_SUB,  OP_SBC,  OP_CP,   OP_DEC,
        OP_NEG,  OP_DJNZ, OP_AND,  OP_OR,
        OP_XOR,  OP_CPL,  OP_BIT,  OP_BS1F,
        OP_BS1B, OP_MIRR, OP_EXTS, OP_EXTZ,
        OP_CCF
    } alu_op_t;

    // top bit of a value at the operand size
    function automatic logic sign_at(input size_t sz, input word_t w);
        case (sz)
            SZ_BYTE: return w[7];
            SZ_WORD: return w[15];
            default: return w[31];
        endcase
    endfunction

    // zero test limited to the operand size
    function automatic logic zero_at(input size_t sz, input word_t w);
        case (sz)
            SZ_BYTE: return w[7:0] == 8'd0;
            SZ_WORD: return w[15:0] == 16'd0;
            default: return w == '0;
        endcase
    endfunction

endpackage

/* logic/alu_defs.svh */
// ~~~~~~~~~~~~~~~~~~~~
// execute stage constants
// data and opcode widths, bit positions in the flag byte
// ~~~~~~~~~~~~~~~~~~~~

`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

`define ALU_DW  32  // operand and result width
`define ALU_OPW 5   // opcode width

// flag byte layout, bits 5 and 3 read as zero
`define FLAG_S 7
`define FLAG_Z 6
`define FLAG_H 4
`define FLAG_V 2
`define FLAG_N 1
`define FLAG_C 0

`endif
